// ==== Makefile ====
TOP = cpu7_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

run: compile
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

// ==== sim/cpu7_tb.sv ====
// each test loads fresh programs under reset; every region must end in HALT and stay below 256 words
`timescale 1ns/100ps

module cpu7_tb
	import cpu7_word_pkg::*, cpu7_core_pkg::*;
();

logic clk;
logic rst_n;
logic prog_we;
logic [ADDR_W-1:0] prog_addr;
prog_word_u prog_data;
logic out_valid;
logic [VALUE_W-1:0] out_value;
logic [CORE_IDX_W-1:0] out_core;
logic done;

logic [15:0] image [PROGRAM_SIZE];      // copy of the program memory contents
int fill [CORES];                       // words placed per region
logic [CORE_IDX_W-1:0] exp_core_q [$];
logic [VALUE_W-1:0] exp_val_q [$];
string test_name;

cpu7_soc dut_i (
	.clk,
	.rst_n,
	.prog_we,
	.prog_addr,
	.prog_data,
	.out_valid,
	.out_value,
	.out_core,
	.done
);

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

function automatic void stop_with_error(string msg);
	$display("%s", msg);
	$display("Done: errors found");
	$fatal(1);
endfunction

function automatic logic [VALUE_W-1:0] rand56();
	return VALUE_W'({$urandom(), $urandom()});
endfunction

function automatic void clear_image();
	for (int a = 0; a < PROGRAM_SIZE; a++)
		image[a] = {WT_IGN, PAYLOAD_W'(a)};  // ignore words tagged with their address
	for (int c = 0; c < CORES; c++)
		fill[c] = 0;
endfunction

function automatic void put(int core, logic [15:0] w);
	assert (fill[core] < REGION_SIZE) else
		stop_with_error($sformatf("program for core %0d does not fit its region", core));
	image[core * REGION_SIZE + fill[core]] = w;
	fill[core]++;
endfunction

function automatic void put_op(int core, opcode_e op);
	put(core, {WT_CPU, 10'b0, op});
endfunction

// lowest chunk first and the push word last
function automatic void put_value(int core, logic [VALUE_W-1:0] v, int chunks, bit with_ign);
	word_type_e wt;
	for (int i = 0; i < chunks; i++) begin
		wt = (i == chunks - 1) ? WT_PSH : WT_DNL;
		if (with_ign && i > 0)
			put(core, {WT_IGN, PAYLOAD_W'(i)});
		put(core, {wt, v[i * PAYLOAD_W +: PAYLOAD_W]});
	end
endfunction

function automatic void gen_outputs(int core, int count, int chunks, bit with_ign);
	for (int i = 0; i < count; i++) begin
		put_value(core, rand56(), chunks, with_ign);
		put_op(core, OP_OUT);
	end
endfunction

// random stack program with depth tracked so it never leaves 1..8 before the final drain
function automatic void gen_alu(int core, int steps);
	opcode_e ops [7];
	opcode_e op;
	int depth;
	ops = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_DUP, OP_DROP, OP_SWAP};
	put_value(core, '1, 4, 1'b0);
	put_value(core, VALUE_W'(3), 1, 1'b0);
	put_op(core, OP_ADD);       // carries out of bit 55
	put_value(core, rand56(), 4, 1'b0);
	depth = 2;
	for (int s = 0; s < steps; s++) begin
		op = ops[$urandom_range(0, 6)];
		if (depth < 2 || (depth < STACK_DEPTH && $urandom_range(0, 3) == 0)) begin
			put_value(core, rand56(), $urandom_range(1, 4), 1'b0);
			depth++;
		end else if (op == OP_DUP && depth == STACK_DEPTH) begin
			put_op(core, OP_SUB);
			depth--;
		end else begin
			put_op(core, op);
			if (op == OP_DUP)
				depth++;
			else if (op != OP_SWAP)
				depth--;
		end
		if (depth >= 2 && $urandom_range(0, 4) == 0) begin
			put_op(core, OP_OUT);
			depth--;
		end
	end
	for (int d = depth; d > 0; d--)
		put_op(core, OP_OUT);
	put_op(core, OP_HALT);
endfunction

// interprets the image turn by turn and queues the expected (core, value) pairs
function automatic void run_model();
	int pc [CORES];
	int depth [CORES];
	bit stopped [CORES];
	logic [VALUE_W-1:0] stk [CORES][STACK_DEPTH];
	logic [VALUE_W-1:0] acc;
	logic [VALUE_W-1:0] a;
	logic [VALUE_W-1:0] b;
	logic [15:0] w;
	opcode_e op;
	int shift;
	int top;
	int cur;
	int live;
	int words;
	bit turn_over;
	bit found;
	for (int c = 0; c < CORES; c++) begin
		pc[c] = c * REGION_SIZE;
		depth[c] = 0;
		stopped[c] = 1'b0;
	end
	cur = 0;
	live = CORES;
	words = 0;
	while (live > 0) begin
		acc = '0;
		shift = 0;
		turn_over = 1'b0;
		while (!turn_over) begin
			w = image[pc[cur]];
			pc[cur]++;
			words++;
			assert (words < 100000) else
				stop_with_error("reference model ran past the end of a program");
			if (w[15:14] == WT_DNL || w[15:14] == WT_PSH) begin
				acc = acc | (VALUE_W'(w[13:0]) << shift);
				shift += PAYLOAD_W;
				if (w[15:14] == WT_PSH) begin
					stk[cur][depth[cur]] = acc;
					depth[cur]++;
					turn_over = 1'b1;
				end
			end else if (w[15:14] == WT_CPU) begin
				op = opcode_e'(w[3:0]);
				top = depth[cur] - 1;
				turn_over = 1'b1;
				case (op)
				OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
					a = stk[cur][top - 1];  // second from top
					b = stk[cur][top];
					case (op)
					OP_ADD: stk[cur][top - 1] = a + b;
					OP_SUB: stk[cur][top - 1] = a - b;
					OP_AND: stk[cur][top - 1] = a & b;
					default: stk[cur][top - 1] = a ^ b;
					endcase
					depth[cur]--;
				end
				OP_DUP: begin
					stk[cur][top + 1] = stk[cur][top];
					depth[cur]++;
				end
				OP_DROP:
					depth[cur]--;
				OP_SWAP: begin
					a = stk[cur][top];
					stk[cur][top] = stk[cur][top - 1];
					stk[cur][top - 1] = a;
				end
				OP_OUT: begin
					exp_core_q.push_back(CORE_IDX_W'(cur));
					exp_val_q.push_back(stk[cur][top]);
					depth[cur]--;
				end
				OP_HALT: begin
					stopped[cur] = 1'b1;
					live--;
				end
				default: ;
				endcase
			end
		end
		found = 1'b0;
		for (int k = 1; k <= CORES; k++) begin
			if (!found && !stopped[(cur + k) % CORES]) begin
				cur = (cur + k) % CORES;
				found = 1'b1;
			end
		end
	end
endfunction

task automatic run_test(string name);
	int cycles;
	int expected;
	test_name = name;
	run_model();
	expected = exp_val_q.size();
	@(posedge clk);
	#1;
	rst_n = 1'b0;
	for (int c = 0; c < CORES; c++) begin
		for (int i = 0; i < fill[c]; i++) begin
			prog_we = 1'b1;
			prog_addr = ADDR_W'(c * REGION_SIZE + i);
			prog_data = image[c * REGION_SIZE + i];
			@(posedge clk);
			#1;
		end
	end
	prog_we = 1'b0;
	repeat (10) @(posedge clk);
	#1;
	rst_n = 1'b1;
	assert (!done) else
		stop_with_error($sformatf("done was high right after reset in test %s", name));
	cycles = 0;
	while (!done) begin
		@(posedge clk);
		#1;
		cycles++;
		assert (cycles < 20000) else
			stop_with_error($sformatf("timeout while waiting for done in test %s", name));
	end
	assert (exp_val_q.size() == 0) else
		stop_with_error($sformatf("test %s reached done with %0d outputs never seen",
			name, exp_val_q.size()));
	repeat (20) begin       // quiet period for stray outputs
		@(posedge clk);
		#1;
		assert (done) else
			stop_with_error($sformatf("done dropped after rising in test %s", name));
	end
	$display("test %s: %0d outputs compared", name, expected);
endtask

// compares every out_valid pulse against the head of the expected queue
always @(negedge clk) begin
	if (rst_n && out_valid) begin
		assert (exp_val_q.size() > 0) else
			stop_with_error($sformatf("test %s core %0d emitted an unexpected value",
				test_name, out_core));
		assert (out_core == exp_core_q[0] && out_value == exp_val_q[0]) else
			stop_with_error($sformatf(
				"FAILED %s expected core %0d value 0x%014h actual core %0d value 0x%014h",
				test_name, exp_core_q[0], exp_val_q[0], out_core, out_value));
		assert (!done) else
			stop_with_error($sformatf("test %s: done was high while a core still emitted",
				test_name));
		void'(exp_core_q.pop_front());
		void'(exp_val_q.pop_front());
	end
end

initial begin
	rst_n = 1'b0;
	prog_we = 1'b0;
	prog_addr = '0;
	prog_data = '0;
	test_name = "reset";
	void'($urandom(68));

	clear_image();
	for (int c = 0; c < CORES; c++) begin
		gen_outputs(c, 3, 1, 1'b0);  // single chunk constants
		put_op(c, OP_HALT);
	end
	run_test("push_out");

	clear_image();
	for (int c = 0; c < CORES; c++) begin
		for (int n = 2; n <= 4; n++)
			gen_outputs(c, 1, n, n != 3);
		put_op(c, OP_HALT);
	end
	run_test("multi_chunk");

	clear_image();
	for (int c = 0; c < CORES; c++)
		gen_alu(c, 30);
	run_test("alu_ops");

	clear_image();
	gen_outputs(0, 1, 2, 1'b0);
	put_op(0, OP_HALT);          // core 0 leaves early
	for (int c = 1; c < CORES; c++) begin
		gen_outputs(c, 4 + c, 3, 1'b1);
		put_op(c, OP_HALT);
	end
	run_test("uneven_halt");

	clear_image();
	for (int c = 0; c < CORES - 1; c++)
		put_op(c, OP_HALT);
	gen_outputs(CORES - 1, 5, 4, 1'b1);
	put_op(CORES - 1, OP_HALT);
	run_test("done_flag");

	$display("Done: no errors");
	$finish;
end

endmodule

// ==== verilog.f ====
verilog/cpu7_core_pkg.sv
verilog/cpu7_word_pkg.sv
verilog/program_rom.sv
verilog/word_sequencer.sv
verilog/stack_core.sv
verilog/output_stage.sv
verilog/cpu7_soc.sv
sim/cpu7_tb.sv

// ==== verilog/cpu7_core_pkg.sv ====
// two cores share one 1024-word program in 256-word regions; stack pointer wraps unchecked
package cpu7_core_pkg;

	localparam int CORES = 2;
	localparam int CORE_IDX_W = (CORES > 1) ? $clog2(CORES) : 1;
	localparam int VALUE_W = 56;                    // four 14-bit chunks
	localparam int OFFSET_W = $clog2(VALUE_W) + 1;  // accumulator bit offset
	localparam int STACK_DEPTH = 8;
	localparam int SP_W = $clog2(STACK_DEPTH);
	localparam int REGION_SIZE = 256;               // words per core region

	// binary ops combine second-from-top with top
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_XOR  = 4'h4,
		OP_DUP  = 4'h5,
		OP_DROP = 4'h6,
		OP_SWAP = 4'h7,
		OP_OUT  = 4'h8,
		OP_HALT = 4'h9
	} opcode_e;

	typedef struct packed {
		logic               push_en;
		logic [VALUE_W-1:0] push_value;
		logic               instr_en;
		opcode_e            opcode;
		logic               pc_step;
	} core_cmd_t;

	typedef struct packed {
		logic               out_en;
		logic [VALUE_W-1:0] out_value;
	} core_out_t;

endpackage

// ==== verilog/cpu7_soc.sv ====
// load the program through prog_we while reset is held; each core starts at its region base
`timescale 1ns/100ps

module cpu7_soc
	import cpu7_word_pkg::*, cpu7_core_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  prog_we,
	input  logic [ADDR_W-1:0]     prog_addr,
	input  prog_word_u            prog_data,
	output logic                  out_valid,
	output logic [VALUE_W-1:0]    out_value,
	output logic [CORE_IDX_W-1:0] out_core,
	output logic                  done
);

prog_word_u cur_word;
logic [ADDR_W-1:0] read_addr;
logic [ADDR_W-1:0] core_pc [CORES];
logic [CORES-1:0] core_busy;
logic [CORES-1:0] core_halted;
logic [CORES-1:0] core_en;
core_cmd_t cmd;
core_out_t core_out [CORES];
logic [CORE_IDX_W-1:0] active_core;

assign read_addr = core_pc[active_core];  // only the active core fetches

program_rom u_rom (
	.clk,
	.write_en(prog_we),
	.write_addr(prog_addr),
	.write_data(prog_data),
	.read_addr,
	.read_data(cur_word)
);

word_sequencer u_seq (
	.clk,
	.rst_n,
	.word(cur_word),
	.core_busy,
	.core_halted,
	.core_en,
	.cmd,
	.active_core
);

for (genvar i = 0; i < CORES; i++) begin : g_core
	stack_core u_core (
		.clk,
		.rst_n,
		.core_index(CORE_IDX_W'(i)),
		.en(core_en[i]),
		.cmd,
		.pc(core_pc[i]),
		.busy(core_busy[i]),
		.halted(core_halted[i]),
		.result(core_out[i])
	);
end

output_stage u_out (
	.clk,
	.rst_n,
	.core_out,
	.halted(core_halted),
	.out_valid,
	.out_value,
	.out_core,
	.done
);

endmodule

// ==== verilog/cpu7_word_pkg.sv ====
// 16-bit program word, type in bits 15:14; compile after cpu7_core_pkg for the opcode type
package cpu7_word_pkg;
	import cpu7_core_pkg::*;

	localparam int PAYLOAD_W = 14;
	localparam int ADDR_W = 10;
	localparam int PROGRAM_SIZE = 1024;

	typedef enum logic [1:0] {
		WT_DNL = 2'b00,  // data chunk, more follows
		WT_PSH = 2'b01,  // final chunk, push the value
		WT_CPU = 2'b10,  // instruction
		WT_IGN = 2'b11   // skipped
	} word_type_e;

	// data reading of a word
	typedef struct packed {
		word_type_e           wtype;
		logic [PAYLOAD_W-1:0] payload;
	} data_view_t;

	// instruction reading, opcode in the low bits
	typedef struct packed {
		word_type_e                             wtype;
		logic [PAYLOAD_W-$bits(opcode_e)-1:0]   spare;
		opcode_e                                opcode;
	} instr_view_t;

	typedef union packed {
		data_view_t  data;
		instr_view_t instr;
	} prog_word_u;

endpackage

// ==== verilog/output_stage.sv ====
// expects at most one out_en per cycle; value and core index hold until the next out_valid
`timescale 1ns/100ps

module output_stage
	import cpu7_core_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  core_out_t             core_out [CORES],
	input  logic [CORES-1:0]      halted,
	output logic                  out_valid,
	output logic [VALUE_W-1:0]    out_value,
	output logic [CORE_IDX_W-1:0] out_core,
	output logic                  done
);

logic any_out;
logic [CORE_IDX_W-1:0] sel;

always_comb begin
	any_out = 1'b0;
	sel = '0;
	for (int i = CORES - 1; i >= 0; i--) begin  // lowest index wins
		if (core_out[i].out_en) begin
			any_out = 1'b1;
			sel = CORE_IDX_W'(i);
		end
	end
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		out_valid <= 1'b0;
		done <= 1'b0;
	end else begin
		out_valid <= any_out;
		done <= &halted;
	end
end

always_ff @(posedge clk) begin
	if (any_out) begin
		out_value <= core_out[sel].out_value;
		out_core <= sel;
	end
end

endmodule

// ==== verilog/program_rom.sv ====
// no initial contents; words must be written through the write port before the run starts
`timescale 1ns/100ps

module program_rom
	import cpu7_word_pkg::*;
(
	input  logic              clk,
	input  logic              write_en,
	input  logic [ADDR_W-1:0] write_addr,
	input  prog_word_u        write_data,
	input  logic [ADDR_W-1:0] read_addr,
	output prog_word_u        read_data
);

prog_word_u mem [PROGRAM_SIZE];

always_ff @(posedge clk) begin
	if (write_en)
		mem[write_addr] <= write_data;
end

assign read_data = mem[read_addr];  // async read, same cycle

endmodule

// ==== verilog/stack_core.sv ====
// stack pointer wraps silently so programs keep depth in 1..8; a halted core ignores commands
`timescale 1ns/100ps

module stack_core
	import cpu7_word_pkg::*, cpu7_core_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [CORE_IDX_W-1:0] core_index,
	input  logic                  en,
	input  core_cmd_t             cmd,
	output logic [ADDR_W-1:0]     pc,
	output logic                  busy,
	output logic                  halted,
	output core_out_t             result
);

logic [VALUE_W-1:0] stack_mem [STACK_DEPTH];
logic [SP_W-1:0] sp;     // points at top entry
logic [SP_W-1:0] sp_up;
logic [SP_W-1:0] sp_dn;
logic [VALUE_W-1:0] tos;
logic [VALUE_W-1:0] nos;
logic act;
logic do_push;
logic do_instr;
logic out_en_q;
logic [VALUE_W-1:0] out_val_q;

assign act = en && !halted;
assign do_push = act && cmd.push_en;
assign do_instr = act && cmd.instr_en;

assign sp_up = sp + SP_W'(1);
assign sp_dn = sp - SP_W'(1);
assign tos = stack_mem[sp];
assign nos = stack_mem[sp_dn];

assign result = '{out_en: out_en_q, out_value: out_val_q};

always_ff @(posedge clk) begin
	if (!rst_n) begin
		pc <= ADDR_W'(int'(core_index) * REGION_SIZE);  // region base
		sp <= '1;                                       // empty so the first push lands in entry 0
		halted <= 1'b0;
		busy <= 1'b0;
		out_en_q <= 1'b0;
	end else begin
		busy <= en && cmd.pc_step;  // one cycle after the step
		out_en_q <= 1'b0;
		if (act && cmd.pc_step)
			pc <= pc + ADDR_W'(1);
		if (do_push)
			sp <= sp_up;
		if (do_instr) begin
			case (cmd.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_DROP:
				sp <= sp_dn;
			OP_DUP:
				sp <= sp_up;
			OP_OUT: begin
				sp <= sp_dn;
				out_en_q <= 1'b1;
			end
			OP_HALT:
				halted <= 1'b1;
			default: ;  // NOP and SWAP keep the depth
			endcase
		end
	end
end

// stack contents and emitted value
always_ff @(posedge clk) begin
	if (do_push)
		stack_mem[sp_up] <= cmd.push_value;
	if (do_instr) begin
		case (cmd.opcode)
		OP_ADD:
			stack_mem[sp_dn] <= nos + tos;  // wraps at 56 bits
		OP_SUB:
			stack_mem[sp_dn] <= nos - tos;
		OP_AND:
			stack_mem[sp_dn] <= nos & tos;
		OP_XOR:
			stack_mem[sp_dn] <= nos ^ tos;
		OP_DUP:
			stack_mem[sp_up] <= tos;
		OP_SWAP: begin
			stack_mem[sp] <= nos;
			stack_mem[sp_dn] <= tos;
		end
		OP_OUT:
			out_val_q <= tos;
		default: ;
		endcase
	end
end

endmodule

// ==== verilog/word_sequencer.sv ====
// at most four data chunks per value, extra chunks are dropped; stops once every core halts
`timescale 1ns/100ps

module word_sequencer
	import cpu7_word_pkg::*, cpu7_core_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  prog_word_u            word,
	input  logic [CORES-1:0]      core_busy,
	input  logic [CORES-1:0]      core_halted,
	output logic [CORES-1:0]      core_en,
	output core_cmd_t             cmd,
	output logic [CORE_IDX_W-1:0] active_core
);

typedef enum logic [2:0] {
	S_READ,
	S_DECODE,
	S_WAIT,
	S_NEXT_CORE,
	S_STOP
} seq_state_e;

seq_state_e state;
prog_word_u word_r;              // word taken in READ
logic [VALUE_W-1:0] accum;
logic [OFFSET_W-1:0] bit_offset;
logic turn_end;                  // push or instruction ends the turn
logic [CORE_IDX_W-1:0] next_core;
logic any_live;

assign core_en = CORES'(1) << active_core;

// nearest following core still running, the active one last
always_comb begin
	next_core = active_core;
	any_live = 1'b0;
	for (int k = CORES; k >= 1; k--) begin
		if (!core_halted[(int'(active_core) + k) % CORES]) begin
			next_core = CORE_IDX_W'((int'(active_core) + k) % CORES);
			any_live = 1'b1;
		end
	end
end

// pulses only during DECODE
always_comb begin
	cmd = '0;
	if (state == S_DECODE) begin
		cmd.pc_step = 1'b1;
		cmd.push_en = (word_r.data.wtype == WT_PSH);
		cmd.instr_en = (word_r.instr.wtype == WT_CPU);
	end
	cmd.push_value = accum;
	cmd.opcode = word_r.instr.opcode;
end

always_ff @(posedge clk) begin
	if (state == S_READ)
		word_r <= word;
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state <= S_READ;
		active_core <= '0;
		accum <= '0;
		bit_offset <= '0;
		turn_end <= 1'b0;
	end else begin
		case (state)
		S_READ: begin
			turn_end <= (word.data.wtype == WT_PSH) || (word.data.wtype == WT_CPU);
			// chunks go in lowest first, ignore and instruction words leave the value alone
			if ((word.data.wtype == WT_DNL) || (word.data.wtype == WT_PSH)) begin
				accum <= accum | (VALUE_W'(word.data.payload) << bit_offset);
				bit_offset <= bit_offset + OFFSET_W'(PAYLOAD_W);
			end
			state <= S_DECODE;
		end
		S_DECODE:
			state <= S_WAIT;
		S_WAIT: begin
			if (!core_busy[active_core])  // busy is high on the first WAIT cycle
				state <= turn_end ? S_NEXT_CORE : S_READ;
		end
		S_NEXT_CORE: begin
			accum <= '0;
			bit_offset <= '0;
			if (any_live) begin
				active_core <= next_core;
				state <= S_READ;
			end else begin
				state <= S_STOP;
			end
		end
		S_STOP:
			state <= S_STOP;  // all cores halted
		default:
			state <= S_READ;
		endcase
	end
end

endmodule
